/* common/sd_cmd_pkg.sv */
package sd_cmd_pkg;

	localparam int FRAME_BITS = 48;  // command and short response
	localparam int LONG_BITS  = 136; // R2 style response

	// command frame as it leaves on the pin, msb first
	typedef struct packed {
		logic        start;
		logic        dir;
		logic [5:0]  index;
		logic [31:0] arg;
		logic [6:0]  crc;
		logic        stop;
	} cmd_frame_t;

	// 48 bit response sits lsb aligned in the 136 bit word
	typedef struct packed {
		logic [87:0] pad;
		logic        start;
		logic        dir;
		logic [5:0]  index;
		logic [31:0] arg;
		logic [6:0]  crc;
		logic        stop;
	} resp_short_t;

	typedef struct packed {
		logic         start;
		logic         dir;
		logic [5:0]   reserved;
		logic [119:0] payload; // cid or csd
		logic [6:0]   crc;
		logic         stop;
	} resp_long_t;

	// crc and stop bit land on the same bits in both views
	typedef union packed {
		resp_short_t short_view;
		resp_long_t  long_view;
	} resp_word_u;

	typedef struct packed {
		logic timeout;
		logic crc_err;
		logic long_resp;
	} resp_status_t;

	// one serial step of x^7 + x^3 + 1
	function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic bit_in);
		logic fb;
		fb = bit_in ^ crc[6];
		return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
	endfunction

endpackage

/* hdl/cmd_frame_decoder.sv */
`timescale 1ns/1ps

module cmd_frame_decoder (
	input  logic                   sd_clock,
	input  logic                   rst_n,
	input  logic                   strobe_in,
	input  logic [39:0]            cmd_to_send,
	input  logic                   busy,
	output sd_cmd_pkg::cmd_frame_t frame,
	output logic                   frame_valid,
	output logic                   expect_long
);
	import sd_cmd_pkg::*;

	cmd_frame_t next_frame;
	logic [6:0] crc;
	logic       accept;
	logic       long_idx;

	assign accept = strobe_in & ~busy;

	// crc over start, dir, index and argument
	always_comb begin
		crc = 7'd0;
		for (int i = 39; i >= 0; i--)
			crc = crc7_next(crc, cmd_to_send[i]);
	end

	always_comb begin
		next_frame.start = cmd_to_send[39];
		next_frame.dir   = cmd_to_send[38];
		next_frame.index = cmd_to_send[37:32];
		next_frame.arg   = cmd_to_send[31:0];
		next_frame.crc   = crc;
		next_frame.stop  = 1'b1;
	end

	// all_send_cid, send_csd and send_cid answer with R2
	assign long_idx = (next_frame.index == 6'd2) || (next_frame.index == 6'd9) ||
		(next_frame.index == 6'd10);

	always_ff @(posedge sd_clock) begin
		if (!rst_n)
			frame_valid <= 1'b0;
		else
			frame_valid <= accept;
	end

	always_ff @(posedge sd_clock) begin
		if (accept) begin
			frame       <= next_frame;
			expect_long <= long_idx;
		end
	end

endmodule

/* cmd_serdes/cmd_serializer.sv */
`timescale 1ns/1ps

module cmd_serializer (
	input  logic                   sd_clock,
	input  logic                   rst_n,
	input  logic                   tx_start,
	input  sd_cmd_pkg::cmd_frame_t frame,
	input  logic                   abort,
	output logic                   cmd_out,
	output logic                   cmd_oe,
	output logic                   tx_done
);
	import sd_cmd_pkg::*;

	logic [FRAME_BITS-1:0] shreg;
	logic [5:0]            bit_cnt;
	logic                  oe_q;
	logic                  last_bit;

	assign last_bit = bit_cnt == 6'(FRAME_BITS - 1);

	// abort releases the pin in the same cycle
	assign cmd_oe  = oe_q & ~abort;
	assign cmd_out = oe_q ? shreg[FRAME_BITS-1] : 1'b1;
	assign tx_done = oe_q & last_bit & ~abort; // with the stop bit on the pin

	always_ff @(posedge sd_clock) begin
		if (!rst_n || abort) begin
			oe_q    <= 1'b0;
			bit_cnt <= 6'd0;
		end else if (tx_start) begin
			oe_q    <= 1'b1;
			bit_cnt <= 6'd0;
		end else if (oe_q) begin
			bit_cnt <= bit_cnt + 6'd1;
			if (last_bit)
				oe_q <= 1'b0;
		end
	end

	// msb first, ones fill in behind
	always_ff @(posedge sd_clock) begin
		if (tx_start)
			shreg <= frame;
		else if (oe_q)
			shreg <= {shreg[FRAME_BITS-2:0], 1'b1};
	end

endmodule

/* cmd_serdes/cmd_deserializer.sv */
`timescale 1ns/1ps

module cmd_deserializer (
	input  logic                   sd_clock,
	input  logic                   rst_n,
	input  logic                   cmd_in,
	input  logic                   rx_arm,
	input  logic                   rx_long,
	input  logic                   abort,
	output logic                   rx_started,
	output logic                   rx_done,
	output sd_cmd_pkg::resp_word_u rx_word,
	output logic                   rx_crc_err
);
	import sd_cmd_pkg::*;

	localparam int SHORT_CRC_END = FRAME_BITS - 8; // bits 47..8
	localparam int LONG_CRC_BEG  = LONG_BITS - 128; // bits 127..8
	localparam int LONG_CRC_END  = LONG_BITS - 8;

	logic [1:0]           sync_q;
	logic                 cmd_s;
	logic                 armed;
	logic                 receiving;
	logic                 long_q;
	logic [7:0]           bit_cnt; // index of the bit now on cmd_s
	logic [LONG_BITS-2:0] shreg;
	logic [6:0]           crc_q;
	logic                 last_bit;
	logic                 in_crc_span;
	resp_word_u           word;

	assign cmd_s = sync_q[1];

	assign last_bit = long_q ? (bit_cnt == 8'(LONG_BITS - 1)) :
		(bit_cnt == 8'(FRAME_BITS - 1));
	assign in_crc_span = long_q ?
		(bit_cnt >= 8'(LONG_CRC_BEG) && bit_cnt < 8'(LONG_CRC_END)) :
		(bit_cnt < 8'(SHORT_CRC_END));

	assign word       = {shreg, cmd_s}; // current bit completes the word
	assign rx_word    = word;
	assign rx_started = armed & ~cmd_s & ~abort;
	assign rx_done    = receiving & last_bit & ~abort;
	assign rx_crc_err = crc_q != word.short_view.crc;

	// pin idles high on the pull-up
	always_ff @(posedge sd_clock) begin
		if (!rst_n)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], cmd_in};
	end

	always_ff @(posedge sd_clock) begin
		if (!rst_n || abort) begin
			armed     <= 1'b0;
			receiving <= 1'b0;
			long_q    <= 1'b0;
			bit_cnt   <= 8'd0;
		end else begin
			if (rx_arm) begin
				armed  <= 1'b1;
				long_q <= rx_long;
			end else if (rx_started) begin
				armed     <= 1'b0;
				receiving <= 1'b1;
				bit_cnt   <= 8'd1;
			end else if (receiving) begin
				bit_cnt <= bit_cnt + 8'd1;
				if (last_bit)
					receiving <= 1'b0;
			end
		end
	end

	// a zero start bit leaves both shreg and crc at zero
	always_ff @(posedge sd_clock) begin
		if (rx_started) begin
			shreg <= '0;
			crc_q <= 7'd0;
		end else if (receiving) begin
			shreg <= {shreg[LONG_BITS-3:0], cmd_s};
			if (in_crc_span)
				crc_q <= crc7_next(crc_q, cmd_s);
		end
	end

endmodule

/* hdl/cmd_phys_controller.sv */
`timescale 1ns/1ps

module cmd_phys_controller #(
	parameter int RESP_TIMEOUT = 64
) (
	input  logic                     sd_clock,
	input  logic                     rst_n,
	input  logic                     idle_in,
	input  logic                     ack_in,
	input  logic                     frame_valid,
	input  logic                     expect_long,
	input  logic                     tx_done,
	input  logic                     rx_started,
	input  logic                     rx_done,
	input  sd_cmd_pkg::resp_word_u   rx_word,
	input  logic                     rx_crc_err,
	output logic                     busy,
	output logic                     ack_out,
	output logic                     tx_start,
	output logic                     rx_arm,
	output logic                     rx_long,
	output logic                     abort,
	output logic                     strobe_out,
	output sd_cmd_pkg::resp_word_u   response,
	output sd_cmd_pkg::resp_status_t status
);
	import sd_cmd_pkg::*;

	localparam int TW = $clog2(RESP_TIMEOUT + 1);

	typedef enum logic [2:0] {
		IDLE,
		SEND,
		WAIT_START,
		RECEIVE,
		HOLD
	} state_t;

	state_t        state;
	logic [TW-1:0] wait_cnt;
	logic          long_q;
	logic          timed_out;

	assign timed_out = (state == WAIT_START) && (wait_cnt == TW'(RESP_TIMEOUT - 1));

	// no new command until the host has taken the last response
	assign busy       = idle_in | frame_valid | (state != IDLE);
	assign ack_out    = frame_valid & ~idle_in & (state == IDLE);
	assign strobe_out = state == HOLD;
	assign rx_long    = long_q;
	assign abort      = idle_in | timed_out; // timeout also disarms the receiver

	always_ff @(posedge sd_clock) begin
		if (!rst_n || idle_in) begin
			state    <= IDLE;
			tx_start <= 1'b0;
			rx_arm   <= 1'b0;
			long_q   <= 1'b0;
			wait_cnt <= '0;
		end else begin
			tx_start <= 1'b0;
			rx_arm   <= 1'b0;
			case (state)
				IDLE: begin
					if (frame_valid) begin
						state    <= SEND;
						tx_start <= 1'b1;
						long_q   <= expect_long;
					end
				end
				SEND: begin
					if (tx_done) begin
						state    <= WAIT_START;
						rx_arm   <= 1'b1; // pin already released here
						wait_cnt <= '0;
					end
				end
				WAIT_START: begin
					if (timed_out)
						state <= HOLD;
					else if (rx_started)
						state <= RECEIVE;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				RECEIVE: begin
					if (rx_done)
						state <= HOLD;
				end
				HOLD: begin
					if (ack_in)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// response register, held while strobe_out is up
	always_ff @(posedge sd_clock) begin
		if (timed_out) begin
			response         <= '0;
			status.timeout   <= 1'b1;
			status.crc_err   <= 1'b0;
			status.long_resp <= long_q;
		end else if (state == RECEIVE && rx_done) begin
			response         <= rx_word;
			status.timeout   <= 1'b0;
			status.crc_err   <= rx_crc_err;
			status.long_resp <= long_q;
		end
	end

endmodule

/* hdl/cmd_phys.sv */
`timescale 1ns/1ps

module cmd_phys #(
	parameter int RESP_TIMEOUT = 64
) (
	input  logic                     sd_clock,
	input  logic                     rst_n,
	input  logic                     strobe_in,
	input  logic                     ack_in,
	input  logic                     idle_in,
	input  logic [39:0]              cmd_to_send,
	output logic                     ack_out,
	output logic                     strobe_out,
	output sd_cmd_pkg::resp_word_u   response,
	output sd_cmd_pkg::resp_status_t status,
	inout  wire                      cmd_pin
);
	import sd_cmd_pkg::*;

	cmd_frame_t frame;
	resp_word_u rx_word;
	logic       frame_valid;
	logic       expect_long;
	logic       busy;
	logic       tx_start;
	logic       tx_done;
	logic       cmd_out;
	logic       cmd_oe;
	logic       rx_arm;
	logic       rx_long;
	logic       rx_started;
	logic       rx_done;
	logic       rx_crc_err;
	logic       abort;

	assign cmd_pin = cmd_oe ? cmd_out : 1'bz; // card side pull-up when released

	cmd_frame_decoder u_decoder (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.strobe_in   (strobe_in),
		.cmd_to_send (cmd_to_send),
		.busy        (busy),
		.frame       (frame),
		.frame_valid (frame_valid),
		.expect_long (expect_long)
	);

	cmd_serializer u_serializer (
		.sd_clock (sd_clock),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.frame    (frame),
		.abort    (abort),
		.cmd_out  (cmd_out),
		.cmd_oe   (cmd_oe),
		.tx_done  (tx_done)
	);

	cmd_deserializer u_deserializer (
		.sd_clock   (sd_clock),
		.rst_n      (rst_n),
		.cmd_in     (cmd_pin),
		.rx_arm     (rx_arm),
		.rx_long    (rx_long),
		.abort      (abort),
		.rx_started (rx_started),
		.rx_done    (rx_done),
		.rx_word    (rx_word),
		.rx_crc_err (rx_crc_err)
	);

	cmd_phys_controller #(
		.RESP_TIMEOUT (RESP_TIMEOUT)
	) u_controller (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.idle_in     (idle_in),
		.ack_in      (ack_in),
		.frame_valid (frame_valid),
		.expect_long (expect_long),
		.tx_done     (tx_done),
		.rx_started  (rx_started),
		.rx_done     (rx_done),
		.rx_word     (rx_word),
		.rx_crc_err  (rx_crc_err),
		.busy        (busy),
		.ack_out     (ack_out),
		.tx_start    (tx_start),
		.rx_arm      (rx_arm),
		.rx_long     (rx_long),
		.abort       (abort),
		.strobe_out  (strobe_out),
		.response    (response),
		.status      (status)
	);

endmodule

/* tests/cmd_phys_checker.sv */
`timescale 1ns/1ps

module cmd_phys_checker (
	input logic sd_clock,
	input logic rst_n,
	input logic strobe_in,
	input logic ack_out,
	input logic ack_in,
	input logic idle_in,
	input logic strobe_out,
	input logic cmd_oe,
	input logic rx_arm,
	input logic rx_armed
);

	int   fail_count = 0; // read back by the testbench
	logic in_flight;      // from ack_out until the host takes the result
	logic host_busy;

	assign host_busy = in_flight | ack_out | idle_in;

	always_ff @(posedge sd_clock) begin
		if (!rst_n || idle_in)
			in_flight <= 1'b0;
		else if (ack_out)
			in_flight <= 1'b1;
		else if (strobe_out && ack_in)
			in_flight <= 1'b0;
	end

	// sync reset must leave the result strobe low
	strobe_low_after_reset: assert property (@(posedge sd_clock) !rst_n |=> !strobe_out)
		else begin
			fail_count++;
			$error("strobe_out high after a reset cycle");
		end

	strobe_held: assert property (@(posedge sd_clock) disable iff (!rst_n || idle_in)
		strobe_out && !ack_in |=> strobe_out)
		else begin
			fail_count++;
			$error("strobe_out dropped without ack_in");
		end

	ack_after_strobe: assert property (@(posedge sd_clock) disable iff (!rst_n || idle_in)
		strobe_in && !host_busy |=> ack_out)
		else begin
			fail_count++;
			$error("accepted strobe_in not followed by ack_out");
		end

	ack_only_when_accepted: assert property (@(posedge sd_clock) disable iff (!rst_n)
		ack_out |-> $past(strobe_in && !host_busy))
		else begin
			fail_count++;
			$error("ack_out without an accepted strobe_in");
		end

	// receiver armed means the host has let go of the line
	pin_free_while_armed: assert property (@(posedge sd_clock) disable iff (!rst_n)
		!(cmd_oe && (rx_arm || rx_armed)))
		else begin
			fail_count++;
			$error("cmd_oe high while the deserializer is armed");
		end

endmodule

bind cmd_phys cmd_phys_checker u_checker (
	.sd_clock   (sd_clock),
	.rst_n      (rst_n),
	.strobe_in  (strobe_in),
	.ack_out    (ack_out),
	.ack_in     (ack_in),
	.idle_in    (idle_in),
	.strobe_out (strobe_out),
	.cmd_oe     (cmd_oe),
	.rx_arm     (rx_arm),
	.rx_armed   (u_deserializer.armed)
);

/* tests/tb_cmd_phys.sv */
`timescale 1ns/1ps

module tb_cmd_phys;
	import sd_cmd_pkg::*;

	localparam int CYCLE_LIMIT  = 6 * 400;
	localparam int MODE_SHORT   = 0;
	localparam int MODE_LONG    = 1;
	localparam int MODE_BAD_CRC = 2;
	localparam int MODE_SILENT  = 3;

	logic         sd_clock;
	logic         rst_n;
	logic         strobe_in;
	logic         ack_in;
	logic         idle_in;
	logic [39:0]  cmd_to_send;
	logic         ack_out;
	logic         strobe_out;
	resp_word_u   response;
	resp_status_t status;
	wire          cmd_pin;
	logic         card_oe;
	logic         card_bit;

	logic [31:0] rng = 32'h8509;
	int          cycles = 0;
	int          err_cnt = 0;
	int          err_base = 0;
	int          passed = 0;
	int          failed = 0;
	int          total_err;
	string       test_name;

	pullup (cmd_pin);
	assign cmd_pin = card_oe ? card_bit : 1'bz; // card side driver

	cmd_phys #(
		.RESP_TIMEOUT (64)
	) u_cmd_phys (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.strobe_in   (strobe_in),
		.ack_in      (ack_in),
		.idle_in     (idle_in),
		.cmd_to_send (cmd_to_send),
		.ack_out     (ack_out),
		.strobe_out  (strobe_out),
		.response    (response),
		.status      (status),
		.cmd_pin     (cmd_pin)
	);

	initial begin
		sd_clock = 1'b0;
		forever #20 sd_clock = ~sd_clock;
	end

	always @(posedge sd_clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// long division by x^7+x^3+1 over the n low bits of data
	function automatic logic [6:0] crc7_of(input logic [119:0] data, input int n);
		logic [126:0] r;
		r = {data, 7'd0};
		for (int i = n + 6; i >= 7; i--)
			if (r[i])
				r[i -: 8] = r[i -: 8] ^ 8'h89;
		return r[6:0];
	endfunction

	task automatic check_value(input string what, input logic [135:0] expected,
		input logic [135:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s: %s", test_name, msg);
			err_cnt++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_base  = err_cnt;
	endtask

	task automatic finish_test();
		if (err_cnt == err_base) begin
			passed++;
			$display("test %s: pass", test_name);
		end else begin
			failed++;
			$display("test %s: fail", test_name);
		end
	endtask

	task automatic issue_command(input logic [39:0] cmd);
		@(posedge sd_clock);
		strobe_in   <= 1'b1;
		cmd_to_send <= cmd;
		@(posedge sd_clock);
		strobe_in <= 1'b0;
		@(negedge sd_clock);
		check_true(ack_out === 1'b1, "no ack_out one cycle after strobe_in");
	endtask

	// a second command while the response is held must be ignored
	task automatic strobe_while_busy();
		@(posedge sd_clock);
		strobe_in <= 1'b1;
		@(posedge sd_clock);
		strobe_in <= 1'b0;
		@(negedge sd_clock);
		check_true(ack_out === 1'b0, "ack_out for a strobe_in while a response was held");
	endtask

	// card listens from the start bit on
	task automatic card_take_command(output logic [47:0] bits);
		@(negedge sd_clock);
		while (cmd_pin !== 1'b0)
			@(negedge sd_clock);
		bits[47] = 1'b0;
		for (int i = 46; i >= 0; i--) begin
			@(negedge sd_clock);
			bits[i] = cmd_pin;
		end
	endtask

	task automatic card_send(input logic [135:0] word, input int nbits);
		repeat (5) @(posedge sd_clock);
		for (int i = nbits - 1; i >= 0; i--) begin
			card_oe  <= 1'b1;
			card_bit <= word[i];
			@(posedge sd_clock);
		end
		card_oe  <= 1'b0;
		card_bit <= 1'b1;
	endtask

	task automatic wait_strobe();
		@(negedge sd_clock);
		while (strobe_out !== 1'b1)
			@(negedge sd_clock);
	endtask

	task automatic ack_response();
		@(posedge sd_clock);
		ack_in <= 1'b1;
		@(posedge sd_clock);
		ack_in <= 1'b0;
	endtask

	task automatic transact(input logic [5:0] idx, input int mode);
		logic [31:0]  arg;
		logic [39:0]  body;
		logic [39:0]  resp40;
		logic [47:0]  seen;
		logic [47:0]  exp_frame;
		logic [127:0] rnd128;
		logic [119:0] payload;
		logic [135:0] word;
		logic [6:0]   crc;
		int           nbits;
		arg       = next_rand();
		body      = {2'b01, idx, arg};
		exp_frame = {body, crc7_of(120'(body), 40), 1'b1};
		issue_command(body);
		card_take_command(seen);
		check_value("command frame", 136'(exp_frame), 136'(seen));
		if (mode == MODE_LONG) begin
			for (int k = 0; k < 4; k++)
				rnd128 = {rnd128[95:0], next_rand()};
			payload = rnd128[119:0];
			word    = {2'b00, 6'h3f, payload, crc7_of(payload, 120), 1'b1};
			nbits   = LONG_BITS;
		end else begin
			resp40 = {2'b00, idx, arg ^ 32'h5a5a_c3c3}; // echo with scrambled argument
			crc    = crc7_of(120'(resp40), 40);
			if (mode == MODE_BAD_CRC)
				crc = crc ^ 7'h10;
			word  = {88'd0, resp40, crc, 1'b1};
			nbits = FRAME_BITS;
		end
		if (mode != MODE_SILENT)
			card_send(word, nbits);
		wait_strobe();
		case (mode)
			MODE_SHORT: begin
				check_value("short response", word, 136'(response.short_view));
				check_value("status", 136'(3'b000), 136'(status));
			end
			MODE_LONG: begin
				check_value("long payload", 136'(payload), 136'(response.long_view.payload));
				check_value("status", 136'(3'b001), 136'(status));
			end
			MODE_BAD_CRC: check_value("status", 136'(3'b010), 136'(status));
			default: begin
				check_value("status", 136'(3'b100), 136'(status));
				check_value("response", 136'd0, 136'(response));
			end
		endcase
		strobe_while_busy();
		ack_response();
	endtask

	task automatic abort_during_send();
		logic [31:0] arg;
		arg = next_rand();
		issue_command({2'b01, 6'd17, arg});
		@(negedge sd_clock);
		while (cmd_pin !== 1'b0)
			@(negedge sd_clock);
		repeat (10) @(negedge sd_clock); // well inside the frame
		@(posedge sd_clock);
		idle_in <= 1'b1;
		@(negedge sd_clock);
		check_true(u_cmd_phys.cmd_oe === 1'b0 && cmd_pin === 1'b1,
			"pin still driven one cycle after idle_in");
		repeat (3) @(posedge sd_clock);
		idle_in <= 1'b0;
		repeat (100) begin
			@(negedge sd_clock);
			check_true(strobe_out === 1'b0, "strobe_out rose after an aborted command");
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		strobe_in   = 1'b0;
		ack_in      = 1'b0;
		idle_in     = 1'b0;
		cmd_to_send = 40'd0;
		card_oe     = 1'b0;
		card_bit    = 1'b1;
		repeat (16) @(posedge sd_clock);
		rst_n <= 1'b1;
		repeat (2) @(posedge sd_clock);

		start_test("command_frame");
		transact(6'd13, MODE_SHORT);
		finish_test();
		start_test("short_response");
		transact(6'd17, MODE_SHORT);
		finish_test();
		start_test("long_response");
		transact(6'd2, MODE_LONG);
		transact(6'd9, MODE_LONG);
		finish_test();
		start_test("bad_crc");
		transact(6'd7, MODE_BAD_CRC);
		finish_test();
		start_test("no_response");
		transact(6'd8, MODE_SILENT);
		finish_test();
		start_test("idle_abort");
		abort_during_send();
		finish_test();

		total_err = err_cnt + u_cmd_phys.u_checker.fail_count;
		$display("%0d tests: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
			passed + failed, passed, failed, err_cnt, u_cmd_phys.u_checker.fail_count);
		if (failed == 0 && total_err == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
common/sd_cmd_pkg.sv
hdl/cmd_frame_decoder.sv
cmd_serdes/cmd_serializer.sv
cmd_serdes/cmd_deserializer.sv
hdl/cmd_phys_controller.sv
hdl/cmd_phys.sv
tests/cmd_phys_checker.sv
tests/tb_cmd_phys.sv

/* Bender.yml */
package:
  name: sd_cmd_phys

sources:
  - common/sd_cmd_pkg.sv
  - hdl/cmd_frame_decoder.sv
  - cmd_serdes/cmd_serializer.sv
  - cmd_serdes/cmd_deserializer.sv
  - hdl/cmd_phys_controller.sv
  - hdl/cmd_phys.sv
  - target: test
    files:
      - tests/cmd_phys_checker.sv
      - tests/tb_cmd_phys.sv
